//--- wr_path_defs.svh
// width and depth constants; WR_PU_ID_W must cover WR_NUM_PU, and queue depths are powers of two
`ifndef WR_PATH_DEFS_SVH
`define WR_PATH_DEFS_SVH

// request address, byte granular
`define WR_ADDR_W 32

// one beat of write data
`define WR_DATA_W 64

// output buffer lanes
`define WR_NUM_PU 2
`define WR_PU_ID_W 1  // log2 of WR_NUM_PU, at least 1

// length field of a macro request, counted in beats
`define WR_SIZE_W 10

// address step between beats, equals WR_DATA_W / 8
`define WR_BEAT_BYTES 8

// queue depths as log2
`define WR_MACRO_Q_LOG 2  // 4 macro requests
`define WR_BEAT_Q_LOG 3   // 8 beats in flight before memory

`endif

//--- wr_path_pkg.sv
// request structs and sequencer state; field widths come from the defs header
`default_nettype none

`include "wr_path_defs.svh"

package wr_path_pkg;

  // one macro write request as held in the macro queue
  typedef struct packed {
    logic [`WR_ADDR_W-1:0]  addr;   // first beat address
    logic [`WR_SIZE_W-1:0]  beats;  // length in beats, zero allowed
    logic [`WR_PU_ID_W-1:0] pu_id;  // source output buffer
  } macro_req_t;

  // one beat request towards memory
  typedef struct packed {
    logic [`WR_ADDR_W-1:0] addr;
    logic [`WR_DATA_W-1:0] data;
  } beat_req_t;

  // sequencer is either waiting for a macro request or splitting one
  typedef enum logic {
    seq_idle,
    seq_active
  } seq_state_e;

endpackage

`default_nettype wire

//--- fifo_if.sv
// one queue's push/pop bundle; push and pop are single-cycle strobes, push only while full is low
`default_nettype none
`timescale 1ns/1ps

interface fifo_if #(
  parameter int WIDTH = 8
);

  logic             push;       // write strobe
  logic [WIDTH-1:0] push_data;
  logic             full;
  logic             pop;        // removes the head at the edge
  logic [WIDTH-1:0] pop_data;   // head item, fall through
  logic             valid;      // head present, inverse of empty
  logic             empty;

  // producer side; empty is visible so the producer can tell when everything has drained
  modport writer (
    output push,
    output push_data,
    input  full,
    input  empty
  );

  // consumer side
  modport reader (
    output pop,
    input  pop_data,
    input  valid,
    input  empty
  );

  // the storage itself
  modport queue (
    input  push,
    input  push_data,
    output full,
    input  pop,
    output pop_data,
    output valid,
    output empty
  );

endinterface

`default_nettype wire

//--- req_fifo.sv
// fall-through queue of 2**LOG_DEPTH entries; push while full is dropped, pop while empty is ignored
`default_nettype none
`timescale 1ns/1ps

module req_fifo #(
  parameter int WIDTH     = 8,
  parameter int LOG_DEPTH = 2
) (
  input logic  clk,
  input logic  rst,
  fifo_if.queue q
);

  localparam int DEPTH = 1 << LOG_DEPTH;

  logic [WIDTH-1:0]     mem [DEPTH];  // entry storage, no reset
  logic [LOG_DEPTH-1:0] wr_ptr;       // next free slot
  logic [LOG_DEPTH-1:0] rd_ptr;       // head slot
  logic [LOG_DEPTH:0]   count;        // one extra bit so full is representable
  logic                 do_push;
  logic                 do_pop;

  assign do_push = q.push && !q.full;   // drop on full
  assign do_pop  = q.pop && !q.empty;   // ignore on empty

  // pointers and occupancy
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= wr_ptr + 1'b1;  // wraps since depth is a power of two
      if (do_pop) rd_ptr <= rd_ptr + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // both or neither keeps occupancy
      endcase
    end
  end

  // storage write
  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= q.push_data;
    end
  end

  // status from the count
  assign q.full     = (count == (LOG_DEPTH+1)'(DEPTH));
  assign q.empty    = (count == '0);
  assign q.valid    = !q.empty;
  assign q.pop_data = mem[rd_ptr];  // head shows without a pop, valid one cycle after push

  // the writer must honour full; a push here would be silently lost
  a_no_push_when_full : assert property (
    @(posedge clk) disable iff (rst) q.push |-> !q.full
  ) else $error("req_fifo: push while full, item lost");

endmodule

`default_nettype wire

//--- burst_sequencer.sv
// splits one macro request at a time into beats; a zero-length request only produces wr_done
`default_nettype none
`timescale 1ns/1ps

`include "wr_path_defs.svh"

module burst_sequencer (
  input  logic                             clk,
  input  logic                             rst,
  fifo_if.reader                           macro_q,
  fifo_if.writer                           beat_q,
  input  logic [`WR_NUM_PU-1:0]            outbuf_empty,      // low means that PU's lane is valid
  input  logic [`WR_NUM_PU*`WR_DATA_W-1:0] data_from_outbuf,  // lane i at bits i*64 up
  output logic [`WR_NUM_PU-1:0]            outbuf_pop,        // consumes the lane word at the edge
  output logic                             wr_ready,
  output logic                             wr_done
);

  wr_path_pkg::seq_state_e       state;
  logic [`WR_ADDR_W-1:0]         cur_addr;    // address of the next beat
  logic [`WR_SIZE_W-1:0]         beats_left;  // beats still to issue
  logic [`WR_PU_ID_W-1:0]        cur_pu;      // selected output buffer
  wr_path_pkg::macro_req_t       head;        // macro queue head
  wr_path_pkg::beat_req_t        beat;        // beat being pushed
  logic [`WR_DATA_W-1:0]         lane_data;
  logic                          issue;       // pop one word and push one beat this cycle
  logic [`WR_SIZE_W-1:0]         next_left;
  logic                          finish;      // last beat issued or nothing to issue

  assign head = macro_q.pop_data;

  // lane select for the active PU
  assign lane_data = data_from_outbuf[cur_pu*`WR_DATA_W +: `WR_DATA_W];

  // one beat per cycle when the buffer has a word and the beat queue has room
  assign issue = (state == wr_path_pkg::seq_active) && (beats_left != '0)
              && !outbuf_empty[cur_pu] && !beat_q.full;

  assign next_left = issue ? beats_left - 1'b1 : beats_left;
  assign finish    = (state == wr_path_pkg::seq_active) && (next_left == '0);

  // head is taken only while idle and loaded at the same edge
  assign macro_q.pop = (state == wr_path_pkg::seq_idle) && macro_q.valid;

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= wr_path_pkg::seq_idle;
      beats_left <= '0;
      cur_pu     <= '0;
    end else begin
      case (state)
        wr_path_pkg::seq_idle: begin
          if (macro_q.valid) begin
            state      <= wr_path_pkg::seq_active;
            beats_left <= head.beats;
            cur_pu     <= head.pu_id;
          end
        end
        wr_path_pkg::seq_active: begin
          beats_left <= next_left;
          if (finish) state <= wr_path_pkg::seq_idle;  // zero length lands here after one cycle
        end
        default: state <= wr_path_pkg::seq_idle;
      endcase
    end
  end

  // beat address is only meaningful while active
  always_ff @(posedge clk) begin
    if (macro_q.pop) begin
      cur_addr <= head.addr;
    end else if (issue) begin
      cur_addr <= cur_addr + `WR_ADDR_W'(`WR_BEAT_BYTES);
    end
  end

  // beat request out
  assign beat.addr      = cur_addr;
  assign beat.data      = lane_data;
  assign beat_q.push    = issue;
  assign beat_q.push_data = beat;

  // pop only the selected lane
  always_comb begin
    outbuf_pop = '0;
    if (issue) outbuf_pop[cur_pu] = 1'b1;
  end

  // nothing queued and nothing in flight
  assign wr_ready = macro_q.empty && beat_q.empty && (state == wr_path_pkg::seq_idle);

  // one cycle after the last beat leaves the sequencer
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_done <= 1'b0;
    end else begin
      wr_done <= finish;
    end
  end

  // buffer pops go to exactly the PU that the current request named
  a_pop_current_pu : assert property (
    @(posedge clk) disable iff (rst) |outbuf_pop |-> $onehot(outbuf_pop) && outbuf_pop[cur_pu]
  ) else $error("burst_sequencer: outbuf_pop not one-hot on the current PU");

  // idle means no words are taken from any buffer
  a_no_pop_idle : assert property (
    @(posedge clk) disable iff (rst) (state == wr_path_pkg::seq_idle) |-> (outbuf_pop == '0)
  ) else $error("burst_sequencer: output buffer popped while idle");

endmodule

`default_nettype wire

//--- wr_path_top.sv
// write path top; keep at most four macro requests outstanding, a wr_req on a full queue is lost
`default_nettype none
`timescale 1ns/1ps

`include "wr_path_defs.svh"

module wr_path_top (
  input  logic                             clk,
  input  logic                             rst,
  // macro requests
  input  logic                             wr_req,
  input  logic [`WR_ADDR_W-1:0]            wr_addr,
  input  logic [`WR_SIZE_W-1:0]            wr_req_size,  // in 8-byte beats
  input  logic [`WR_PU_ID_W-1:0]           wr_pu_id,
  output logic                             wr_ready,
  output logic                             wr_done,
  // output buffers
  input  logic [`WR_NUM_PU-1:0]            outbuf_empty,
  input  logic [`WR_NUM_PU*`WR_DATA_W-1:0] data_from_outbuf,
  output logic [`WR_NUM_PU-1:0]            outbuf_pop,
  // memory request port
  output logic                             req_valid,
  input  logic                             req_grant,
  output logic [`WR_ADDR_W-1:0]            req_addr,
  output logic [`WR_DATA_W-1:0]            req_data
);

  localparam int MACRO_W = $bits(wr_path_pkg::macro_req_t);
  localparam int BEAT_W  = $bits(wr_path_pkg::beat_req_t);

  wr_path_pkg::macro_req_t macro_in;   // packed wr_* inputs
  wr_path_pkg::beat_req_t  beat_head;  // memory side view of the beat queue head

  fifo_if #(.WIDTH(MACRO_W)) macro_q_bus ();
  fifo_if #(.WIDTH(BEAT_W))  beat_q_bus ();

  // request in, dropped when the macro queue is full
  assign macro_in.addr         = wr_addr;
  assign macro_in.beats        = wr_req_size;
  assign macro_in.pu_id        = wr_pu_id;
  assign macro_q_bus.push      = wr_req && !macro_q_bus.full;
  assign macro_q_bus.push_data = macro_in;

  req_fifo #(
    .WIDTH     (MACRO_W),
    .LOG_DEPTH (`WR_MACRO_Q_LOG)
  ) macro_q (
    .clk (clk),
    .rst (rst),
    .q   (macro_q_bus.queue)
  );

  burst_sequencer seq (
    .clk              (clk),
    .rst              (rst),
    .macro_q          (macro_q_bus.reader),
    .beat_q           (beat_q_bus.writer),
    .outbuf_empty     (outbuf_empty),
    .data_from_outbuf (data_from_outbuf),
    .outbuf_pop       (outbuf_pop),
    .wr_ready         (wr_ready),
    .wr_done          (wr_done)
  );

  req_fifo #(
    .WIDTH     (BEAT_W),
    .LOG_DEPTH (`WR_BEAT_Q_LOG)
  ) beat_q (
    .clk (clk),
    .rst (rst),
    .q   (beat_q_bus.queue)
  );

  // memory side; head stays put until granted
  assign beat_head      = beat_q_bus.pop_data;
  assign req_valid      = beat_q_bus.valid;
  assign req_addr       = beat_head.addr;
  assign req_data       = beat_head.data;
  assign beat_q_bus.pop = req_valid && req_grant;  // beat leaves on valid and grant

endmodule

`default_nettype wire

//--- tb_wr_path.sv
// directed tests for wr_path_top; keeps at most four requests outstanding and every filled word is consumed
`default_nettype none
`timescale 1ns/1ps

`include "wr_path_defs.svh"

module tb_wr_path;

  localparam int TOTAL_BEATS     = 6 + 18 + 20 + 12 + 5;  // beats over all five tests
  localparam int WATCHDOG_CYCLES = TOTAL_BEATS * 40;

  logic                             clk = 1'b0;
  logic                             rst;
  logic                             wr_req;
  logic [`WR_ADDR_W-1:0]            wr_addr;
  logic [`WR_SIZE_W-1:0]            wr_req_size;
  logic [`WR_PU_ID_W-1:0]           wr_pu_id;
  logic                             wr_ready;
  logic                             wr_done;
  logic [`WR_NUM_PU-1:0]            outbuf_empty;
  logic [`WR_NUM_PU*`WR_DATA_W-1:0] data_from_outbuf;
  logic [`WR_NUM_PU-1:0]            outbuf_pop;
  logic                             req_valid;
  logic                             req_grant;
  logic [`WR_ADDR_W-1:0]            req_addr;
  logic [`WR_DATA_W-1:0]            req_data;

  logic [`WR_DATA_W-1:0] buf_q [`WR_NUM_PU][$];  // output buffer model, front is the lane word
  int                    fill_cnt [`WR_NUM_PU];  // words written per PU
  int                    exp_cnt [`WR_NUM_PU];   // words claimed by issued requests
  logic [`WR_ADDR_W-1:0] exp_addr_q [$];         // expected beats in macro order
  logic [`WR_DATA_W-1:0] exp_data_q [$];
  logic [`WR_ADDR_W-1:0] exp_head_addr = '0;     // head copies the assertions look at
  logic [`WR_DATA_W-1:0] exp_head_data = '0;
  int                    exp_count = 0;
  int                    grant_pct = 100;        // 100 means grant held high
  int                    pending = 0;            // requests accepted but not yet done
  int                    done_seen = 0;
  int                    dones_want = 0;
  logic                  chk = 1'b0;             // end of test strobe
  int                    errors = 0;
  int                    err_base = 0;
  int                    tests_run = 0;
  int                    tests_failed = 0;

  wr_path_top uut (
    .clk              (clk),
    .rst              (rst),
    .wr_req           (wr_req),
    .wr_addr          (wr_addr),
    .wr_req_size      (wr_req_size),
    .wr_pu_id         (wr_pu_id),
    .wr_ready         (wr_ready),
    .wr_done          (wr_done),
    .outbuf_empty     (outbuf_empty),
    .data_from_outbuf (data_from_outbuf),
    .outbuf_pop       (outbuf_pop),
    .req_valid        (req_valid),
    .req_grant        (req_grant),
    .req_addr         (req_addr),
    .req_data         (req_data)
  );

  always #4 clk = ~clk;  // 8 ns period

  // pu id in the top byte, running count below
  function automatic logic [`WR_DATA_W-1:0] word_value(input int pu, input int n);
    return {8'(pu), 56'(n)};
  endfunction

  // copy the expected head into plain variables, nonblocking so edge sampling sees old values
  task automatic refresh_expected();
    exp_count <= exp_addr_q.size();
    if (exp_addr_q.size() != 0) begin
      exp_head_addr <= exp_addr_q[0];
      exp_head_data <= exp_data_q[0];
    end
  endtask

  task automatic fill_buffer(input int pu, input int n);
    for (int k = 0; k < n; k++) begin
      buf_q[pu].push_back(word_value(pu, fill_cnt[pu]));
      fill_cnt[pu]++;
    end
  endtask

  // called at a falling edge; holds wr_req for one cycle
  task automatic send_request(input logic [`WR_ADDR_W-1:0] addr, input int len, input int pu);
    wr_req      = 1'b1;
    wr_addr     = addr;
    wr_req_size = `WR_SIZE_W'(len);
    wr_pu_id    = `WR_PU_ID_W'(pu);
    for (int k = 0; k < len; k++) begin
      exp_addr_q.push_back(addr + `WR_ADDR_W'(`WR_BEAT_BYTES * k));  // 8 bytes per beat
      exp_data_q.push_back(word_value(pu, exp_cnt[pu]));            // that PU's pop order
      exp_cnt[pu]++;
    end
    dones_want++;
    refresh_expected();
    @(negedge clk);
    wr_req = 1'b0;  // a following call raises it again in the same step
  endtask

  // all requests done and both queues drained
  task automatic wait_drained();
    @(negedge clk);
    while (done_seen < dones_want || !wr_ready) @(negedge clk);
  endtask

  task automatic finish_test(input int num, input string name);
    chk = 1'b1;
    @(negedge clk);
    chk = 1'b0;
    @(negedge clk);  // let the end of test assertion report
    tests_run++;
    if (errors == err_base) begin
      $display("test %0d %s: ok", num, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: %0d errors", num, name, errors - err_base);
    end
    err_base = errors;
  endtask

  // buffer lanes and grant change on the falling edge
  always @(negedge clk) begin
    for (int i = 0; i < `WR_NUM_PU; i++) begin
      outbuf_empty[i] = (buf_q[i].size() == 0);
      if (buf_q[i].size() != 0) data_from_outbuf[i*`WR_DATA_W +: `WR_DATA_W] = buf_q[i][0];
      else data_from_outbuf[i*`WR_DATA_W +: `WR_DATA_W] = '0;
    end
    if (grant_pct >= 100) req_grant = 1'b1;
    else req_grant = ($urandom_range(99, 0) < 32'(grant_pct));
  end

  // memory and buffer bookkeeping at the rising edge
  always @(posedge clk) begin
    if (!rst) begin
      if (req_valid && req_grant && exp_addr_q.size() != 0) begin
        void'(exp_addr_q.pop_front());
        void'(exp_data_q.pop_front());
        refresh_expected();
      end
      for (int i = 0; i < `WR_NUM_PU; i++) begin
        if (outbuf_pop[i] && buf_q[i].size() != 0) void'(buf_q[i].pop_front());
      end
      if (wr_req && !wr_done) pending <= pending + 1;
      if (wr_done && !wr_req) pending <= pending - 1;
      if (wr_done) done_seen <= done_seen + 1;
    end
  end

  a_reset_state : assert property (
    @(posedge clk) $fell(rst) |-> wr_ready && !req_valid && (outbuf_pop == '0) && !wr_done
  ) else begin
    errors++;
    $display("ERROR %0t: outputs not idle after reset", $time);
  end

  // each granted beat matches the next expected address and word
  a_beat_order : assert property (
    @(posedge clk) disable iff (rst)
      (req_valid && req_grant) |->
        (exp_count != 0) && (req_addr == exp_head_addr) && (req_data == exp_head_data)
  ) else begin
    errors++;
    $display("ERROR %0t: beat addr %h data %h, expected addr %h data %h (%0d left)", $time,
             $sampled(req_addr), $sampled(req_data), $sampled(exp_head_addr),
             $sampled(exp_head_data), $sampled(exp_count));
  end

  a_hold_stalled : assert property (
    @(posedge clk) disable iff (rst)
      (req_valid && !req_grant) |=> req_valid && $stable(req_addr) && $stable(req_data)
  ) else begin
    errors++;
    $display("ERROR %0t: request changed while waiting for grant", $time);
  end

  a_pop_nonempty : assert property (
    @(posedge clk) disable iff (rst) (outbuf_pop & outbuf_empty) == '0
  ) else begin
    errors++;
    $display("ERROR %0t: outbuf_pop %b on empty buffer %b", $time,
             $sampled(outbuf_pop), $sampled(outbuf_empty));
  end

  a_done_pulse : assert property (
    @(posedge clk) disable iff (rst) wr_done |=> !wr_done
  ) else begin
    errors++;
    $display("ERROR %0t: wr_done high for more than one cycle", $time);
  end

  a_busy_not_ready : assert property (
    @(posedge clk) disable iff (rst) (pending != 0 && !wr_done) |-> !wr_ready
  ) else begin
    errors++;
    $display("ERROR %0t: wr_ready high with %0d requests pending", $time, $sampled(pending));
  end

  a_test_end : assert property (
    @(posedge clk) disable iff (rst)
      chk |-> (done_seen == dones_want) && (exp_count == 0) && wr_ready
  ) else begin
    errors++;
    $display("ERROR %0t: test end with %0d of %0d wr_done, %0d beats missing", $time,
             $sampled(done_seen), $sampled(dones_want), $sampled(exp_count));
  end

  // hang guard sized from the beat count of all tests
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("TESTS FAILED");
    $finish;
  end

  initial begin
    int seed_draw;
    int stretch;
    seed_draw        = $urandom(32'hfc81_9570);  // one seed for the whole run
    rst              = 1'b1;
    wr_req           = 1'b0;
    wr_addr          = '0;
    wr_req_size      = '0;
    wr_pu_id         = '0;
    req_grant        = 1'b0;
    outbuf_empty     = '1;
    data_from_outbuf = '0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    // single burst from PU0 with grant held high
    fill_buffer(0, 6);
    send_request(32'h0000_1000, 6, 0);
    wait_drained();
    finish_test(1, "reset and single burst");

    // four requests back to back, alternating PUs
    fill_buffer(0, 9);
    fill_buffer(1, 9);
    send_request(32'h0000_2000, 5, 0);
    send_request(32'h0000_3000, 3, 1);
    send_request(32'h0000_4000, 4, 0);
    send_request(32'h0000_5000, 6, 1);
    wait_drained();
    finish_test(2, "queued requests");

    grant_pct = 30;  // about 30 % of cycles granted
    fill_buffer(0, 20);
    send_request(32'h0001_0000, 20, 0);
    wait_drained();
    grant_pct = 100;
    finish_test(3, "grant back-pressure");

    // PU1 runs dry after four words
    fill_buffer(1, 4);
    send_request(32'h0001_8000, 12, 1);
    while (buf_q[1].size() != 0) @(negedge clk);
    stretch = $urandom_range(24, 8);
    repeat (stretch) @(negedge clk);
    fill_buffer(1, 8);
    wait_drained();
    finish_test(4, "starved buffer");

    fill_buffer(1, 5);
    send_request(32'h0002_0000, 0, 0);  // zero length, done only
    send_request(32'h0002_1000, 5, 1);
    wait_drained();
    finish_test(5, "zero-length request");

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sim.f
+incdir+.
wr_path_pkg.sv
fifo_if.sv
req_fifo.sv
burst_sequencer.sv
wr_path_top.sv
tb_wr_path.sv

//--- Makefile
# Verilator build and run of the write path testbench; override any variable on the command line

VERILATOR  ?= verilator
TOP        ?= tb_wr_path
RTL_TOP    ?= wr_path_top
FILELIST   ?= sim.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
TIMESCALE  ?= 1ns/1ps
VFLAGS     ?= --binary --timing --assert --timescale $(TIMESCALE) -Wno-fatal
LINT_FLAGS ?= --lint-only -Wall --timescale $(TIMESCALE)

SRCS     := $(shell grep -v '^+' $(FILELIST))
RTL_SRCS := $(filter-out tb_%,$(SRCS))
BIN      := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(BIN)

$(BIN): $(FILELIST) $(SRCS) wr_path_defs.svh
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# the log decides the result
run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TESTS FAILED" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "TESTS PASSED" $(LOG); then echo "simulation ended without a result"; exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) +incdir+. $(RTL_SRCS) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
